/* Makefile */
VERILATOR ?= verilator
TOP ?= mem_hierarchy_tb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= compile.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* compile.f */
verilog/lc3b_mem_pkg.sv
verilog/l1_cache.sv
verilog/cache_arbiter.sv
verilog/io_counters.sv
verilog/mem_hierarchy.sv
sim/pmem_model.sv
sim/mem_hierarchy_assert.sv
sim/mem_hierarchy_tb.sv

/* sim/mem_hierarchy_assert.sv */
module mem_hierarchy_assert import lc3b_mem_pkg::*;
(
	input logic clk,
	input logic rst_n_i,
	input cpu_req_t dreq_i,
	input cpu_rsp_t drsp_o,
	input pmem_req_t pmem_req_o,
	input pmem_rsp_t pmem_rsp_i
);

pmem_rw_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
	!(pmem_req_o.read && pmem_req_o.write))
	else $error("physical read and write high together");

// held until the memory answers
pmem_req_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
	(pmem_req_o.read || pmem_req_o.write) && !pmem_rsp_i.resp |=> $stable(pmem_req_o))
	else $error("physical request changed before resp");

drsp_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
	drsp_o.resp |-> (dreq_i.read || dreq_i.write))
	else $error("data resp without a held request");

endmodule

bind cache_arbiter mem_hierarchy_assert asrt0 (.*);

/* sim/mem_hierarchy_tb.sv */
module mem_hierarchy_tb import lc3b_mem_pkg::*;
();

localparam int CYCLE_LIMIT = 12000;

typedef struct packed {
	logic check;
	logic is_count;
	lc3b_word val;
} exp_t;

logic clk = 1'b0;
logic rst_n_i;
cpu_req_t ireq, dreq;
cpu_rsp_t irsp, drsp;
pmem_req_t pmem_req;
pmem_rsp_t pmem_rsp;
logic [2:0] mem_delay;

int errors = 0;
int cycles = 0;
logic [31:0] delay_state = 32'hde53;
logic [31:0] traffic_state = 32'hde53;
exp_t iq[$];
exp_t dq[$];

// reference state as a flat word image
lc3b_word ref_mem [32768];
logic [TAG_W-1:0] ref_tag [2][NUM_SETS];
logic ref_valid [2][NUM_SETS];
lc3b_word ref_cnt [4]; // ihits imiss dhits dmiss

mem_hierarchy dut0
(
	.clk,
	.rst_n_i,
	.ireq_i(ireq),
	.irsp_o(irsp),
	.dreq_i(dreq),
	.drsp_o(drsp),
	.pmem_req_o(pmem_req),
	.pmem_rsp_i(pmem_rsp)
);

pmem_model mem0
(
	.clk,
	.rst_n_i,
	.req_i(pmem_req),
	.delay_i(mem_delay),
	.rsp_o(pmem_rsp)
);

function automatic logic [31:0] xorshift(input logic [31:0] x);
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

function automatic lc3b_word ref_access(input bit side, input cpu_req_t r);
	logic [2:0] s;
	logic hit;
	lc3b_word old;
	lc3b_word cnt;
	if (r.addr.io.page == IO_PAGE)
	begin
		cnt = '0;
		if (r.addr.io.reg_sel inside {IO_IHITS, IO_IMISS, IO_DHITS, IO_DMISS})
		begin
			cnt = ref_cnt[r.addr.io.reg_sel[2:1]];
			if (r.write)
				ref_cnt[r.addr.io.reg_sel[2:1]] = '0;
		end
		return cnt;
	end
	s = r.addr.cache.set;
	hit = ref_valid[side][s] && (ref_tag[side][s] == r.addr.cache.tag);
	ref_cnt[{side, !hit}] = ref_cnt[{side, !hit}] + 16'd1;
	ref_valid[side][s] = 1'b1;
	ref_tag[side][s] = r.addr.cache.tag;
	old = ref_mem[r.addr[15:1]];
	if (r.write && r.wmask[0])
		ref_mem[r.addr[15:1]][7:0] = r.wdata[7:0];
	if (r.write && r.wmask[1])
		ref_mem[r.addr[15:1]][15:8] = r.wdata[15:8];
	return old;
endfunction

function automatic lc3b_line ref_line(input logic [15:0] a);
	lc3b_line l;
	for (int w = 0; w < 8; w++)
		l[w*16 +: 16] = ref_mem[{a[15:4], w[2:0]}];
	return l;
endfunction

function automatic cpu_req_t make_req(input logic [15:0] a, input logic wr,
	input lc3b_word wd, input lc3b_mem_wmask m);
	cpu_req_t r;
	r.addr = a;
	r.wdata = wd;
	r.read = !wr;
	r.write = wr;
	r.wmask = m;
	return r;
endfunction

task automatic check_word(input string name, input lc3b_word exp, input lc3b_word act);
	if (exp !== act)
	begin
		errors++;
		$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
	end
endtask

task automatic check_line(input string name, input lc3b_line exp, input lc3b_line act);
	if (exp !== act)
	begin
		errors++;
		$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
	end
endtask

task automatic check_count(input string name, input lc3b_word exp, input lc3b_word act);
	if (exp !== act)
	begin
		errors++;
		$display("CHECK FAILED %s (counter) expected %h actual %h", name, exp, act);
	end
endtask

// side is 0 for fetch and 1 for data
task automatic do_access(input bit side, input cpu_req_t r);
	exp_t e;
	@(negedge clk);
	e.check = r.read;
	e.is_count = (r.addr.io.page == IO_PAGE);
	e.val = ref_access(side, r);
	if (side)
	begin
		dq.push_back(e);
		dreq = r;
	end
	else
	begin
		iq.push_back(e);
		ireq = r;
	end
	do
		@(negedge clk);
	while (!(side ? drsp.resp : irsp.resp));
	@(negedge clk); // held through the write commit
	if (side)
		dreq = '0;
	else
		ireq = '0;
endtask

initial
begin
	forever #4 clk = ~clk;
end

always @(negedge clk)
begin
	delay_state = xorshift(delay_state);
	mem_delay = delay_state[2:0];
end

always @(negedge clk)
begin
	exp_t e;
	if (irsp.resp)
	begin
		if (iq.size() == 0)
		begin
			errors++;
			$display("instruction resp with no request outstanding");
		end
		else
		begin
			e = iq.pop_front();
			if (e.check)
				check_word("irsp.rdata", e.val, irsp.rdata);
		end
	end
	if (drsp.resp)
	begin
		if (dq.size() == 0)
		begin
			errors++;
			$display("data resp with no request outstanding");
		end
		else
		begin
			e = dq.pop_front();
			if (e.check && e.is_count)
				check_count("drsp.rdata", e.val, drsp.rdata);
			else if (e.check)
				check_word("drsp.rdata", e.val, drsp.rdata);
		end
	end
	if (pmem_req.write && pmem_rsp.resp)
		check_line("pmem_req.wdata", ref_line(pmem_req.addr), pmem_req.wdata);
end

always @(posedge clk)
begin
	cycles++;
	if (cycles == CYCLE_LIMIT)
	begin
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Simulation finished: FAIL");
		$finish;
	end
end

initial
begin
	logic [15:0] ia;
	logic [15:0] da;
	lc3b_mem_wmask wm;
	ireq = '0;
	dreq = '0;
	mem_delay = '0;
	rst_n_i = 1'b0;
	for (int a = 0; a < 32768; a++)
		ref_mem[a] = {a[6:0], 1'b0, a[14:7]} ^ 16'h6c39; // same fill as the memory
	for (int s = 0; s < NUM_SETS; s++)
	begin
		ref_valid[0][s] = 1'b0;
		ref_valid[1][s] = 1'b0;
	end
	for (int c = 0; c < 4; c++)
		ref_cnt[c] = '0;
	repeat (10) @(negedge clk);
	rst_n_i = 1'b1;
	repeat (3)
	begin
		@(negedge clk);
		if (irsp.resp || drsp.resp || pmem_req.read || pmem_req.write)
		begin
			errors++;
			$display("outputs active after reset before any request");
		end
	end

	// fetch miss then hit on the same line
	do_access(0, make_req(16'h0104, 1'b0, '0, 2'b11));
	do_access(0, make_req(16'h010a, 1'b0, '0, 2'b11));

	// every byte enable with a read back
	for (int m = 1; m < 4; m++)
	begin
		do_access(1, make_req(16'h4020, 1'b1, 16'h1234 + m * 16'h1111, m[1:0]));
		do_access(1, make_req(16'h4020, 1'b0, '0, 2'b11));
	end

	// dirty line in set 4 then a conflicting read
	do_access(1, make_req(16'h4046, 1'b1, 16'hbeef, 2'b11));
	do_access(1, make_req(16'h4242, 1'b0, '0, 2'b11));
	do_access(1, make_req(16'h4046, 1'b0, '0, 2'b11));

	// both sides together over four tags per set
	for (int i = 0; i < 150; i++)
	begin
		traffic_state = xorshift(traffic_state);
		ia = {7'h00, traffic_state[1:0], traffic_state[4:2], traffic_state[7:5], 1'b0};
		da = {7'h40, traffic_state[9:8], traffic_state[12:10], traffic_state[15:13], 1'b0};
		wm = traffic_state[17:16];
		if (wm == 2'b00)
			wm = 2'b11;
		fork
			do_access(0, make_req(ia, 1'b0, '0, 2'b11));
			do_access(1, make_req(da, traffic_state[18], traffic_state[31:16], wm));
		join
	end

	// read the counters then clear imiss only
	for (int k = 0; k < 4; k++)
		do_access(1, make_req(16'hfff0 + k * 2, 1'b0, '0, 2'b11));
	do_access(1, make_req(16'hfff2, 1'b1, '0, 2'b11));
	do_access(1, make_req(16'hfffa, 1'b0, '0, 2'b11)); // unmapped
	for (int k = 0; k < 4; k++)
		do_access(1, make_req(16'hfff0 + k * 2, 1'b0, '0, 2'b11));

	repeat (4) @(negedge clk);
	if (iq.size() != 0 || dq.size() != 0)
	begin
		errors++;
		$display("requests left without a response");
	end
	$display("errors: %0d", errors);
	if (errors == 0)
		$display("Simulation finished: PASS");
	else
		$display("Simulation finished: FAIL");
	$finish;
end

endmodule

/* sim/pmem_model.sv */
module pmem_model import lc3b_mem_pkg::*;
(
	input logic clk,
	input logic rst_n_i,
	input pmem_req_t req_i,
	input logic [2:0] delay_i, // extra wait cycles from the testbench
	output pmem_rsp_t rsp_o
);

lc3b_line mem [4096];
logic busy;
logic [2:0] wait_cnt;

function automatic lc3b_word fill_word(input logic [15:0] a);
	return {a[7:0], a[15:8]} ^ 16'h6c39;
endfunction

initial
begin
	for (int a = 0; a < 4096; a++)
		for (int w = 0; w < 8; w++)
			mem[a][w*16 +: 16] = fill_word({a[11:0], w[2:0], 1'b0});
end

// a request seen in the resp cycle is the old one still held
always @(posedge clk or negedge rst_n_i)
begin
	if (!rst_n_i)
	begin
		busy <= 1'b0;
		wait_cnt <= '0;
		rsp_o <= '0;
	end
	else
	begin
		rsp_o.resp <= 1'b0;
		if (!busy && !rsp_o.resp && (req_i.read || req_i.write))
		begin
			busy <= 1'b1;
			wait_cnt <= delay_i;
		end
		else if (busy && wait_cnt != 0)
			wait_cnt <= wait_cnt - 3'd1;
		else if (busy)
		begin
			busy <= 1'b0;
			rsp_o.resp <= 1'b1;
			rsp_o.rdata <= mem[req_i.addr[15:4]];
			if (req_i.write)
				mem[req_i.addr[15:4]] <= req_i.wdata;
		end
	end
end

endmodule

/* verilog/cache_arbiter.sv */
module cache_arbiter import lc3b_mem_pkg::*;
(
	input logic clk,
	input logic rst_n_i,
	input cpu_req_t dreq_i,
	output cpu_rsp_t drsp_o,
	output cpu_req_t dcache_req_o,
	input cpu_rsp_t dcache_rsp_i,
	output logic io_read_o,
	output logic io_write_o,
	input lc3b_word io_rdata_i,
	input logic io_resp_i,
	input pmem_req_t ipmem_req_i,
	input pmem_req_t dpmem_req_i,
	output pmem_rsp_t ipmem_rsp_o,
	output pmem_rsp_t dpmem_rsp_o,
	output pmem_req_t pmem_req_o,
	input pmem_rsp_t pmem_rsp_i
);

typedef enum logic [1:0]
{
	g_idle,
	g_inst,
	g_data
} grant_t;

grant_t state, next_state;

logic io_sel;
logic i_pend;
logic d_pend;

assign io_sel = (dreq_i.addr.io.page == IO_PAGE);

// data side goes either to the cache or to the counter block
always_comb
begin
	dcache_req_o = dreq_i;
	dcache_req_o.read = dreq_i.read & ~io_sel;
	dcache_req_o.write = dreq_i.write & ~io_sel;
end

assign io_read_o = dreq_i.read & io_sel;
assign io_write_o = dreq_i.write & io_sel;

always_comb
begin
	if (io_sel)
	begin
		drsp_o.rdata = io_rdata_i;
		drsp_o.resp = io_resp_i;
	end
	else
		drsp_o = dcache_rsp_i;
end

assign i_pend = ipmem_req_i.read | ipmem_req_i.write;
assign d_pend = dpmem_req_i.read | dpmem_req_i.write;

always_comb
begin
	next_state = state;
	case (state)
		g_idle:
		begin
			if (i_pend)
				next_state = g_inst; // fetch side wins a tie
			else if (d_pend)
				next_state = g_data;
		end
		g_inst, g_data:
			if (pmem_rsp_i.resp)
				next_state = g_idle;
		default:
			next_state = g_idle;
	endcase
end

always_ff @(posedge clk or negedge rst_n_i)
begin
	if (!rst_n_i)
		state <= g_idle;
	else
		state <= next_state;
end

always_comb
begin
	case (state)
		g_inst: pmem_req_o = ipmem_req_i;
		g_data: pmem_req_o = dpmem_req_i;
		default: pmem_req_o = '0;
	endcase
end

assign ipmem_rsp_o.rdata = pmem_rsp_i.rdata;
assign ipmem_rsp_o.resp = pmem_rsp_i.resp & (state == g_inst);
assign dpmem_rsp_o.rdata = pmem_rsp_i.rdata;
assign dpmem_rsp_o.resp = pmem_rsp_i.resp & (state == g_data);

endmodule

/* verilog/io_counters.sv */
module io_counters import lc3b_mem_pkg::*;
(
	input logic clk,
	input logic rst_n_i,
	input lc3b_addr addr_i,
	input logic read_i,
	input logic write_i,
	output lc3b_word rdata_o,
	output logic resp_o,
	input lc3b_word ihits_i,
	input lc3b_word imiss_i,
	input lc3b_word dhits_i,
	input lc3b_word dmiss_i,
	output logic clear_ihits_o,
	output logic clear_imiss_o,
	output logic clear_dhits_o,
	output logic clear_dmiss_o
);

lc3b_word sel_count;
logic req;
logic start;
logic served; // set after resp until the request drops

assign req = read_i | write_i;
assign start = req & ~resp_o & ~served;

always_comb
begin
	case (addr_i.io.reg_sel)
		IO_IHITS: sel_count = ihits_i;
		IO_IMISS: sel_count = imiss_i;
		IO_DHITS: sel_count = dhits_i;
		IO_DMISS: sel_count = dmiss_i;
		default: sel_count = '0; // unmapped
	endcase
end

assign clear_ihits_o = start & write_i & (addr_i.io.reg_sel == IO_IHITS);
assign clear_imiss_o = start & write_i & (addr_i.io.reg_sel == IO_IMISS);
assign clear_dhits_o = start & write_i & (addr_i.io.reg_sel == IO_DHITS);
assign clear_dmiss_o = start & write_i & (addr_i.io.reg_sel == IO_DMISS);

always_ff @(posedge clk or negedge rst_n_i)
begin
	if (!rst_n_i)
	begin
		resp_o <= 1'b0;
		served <= 1'b0;
	end
	else
	begin
		resp_o <= start;
		served <= req & (served | resp_o);
	end
end

always_ff @(posedge clk)
begin
	if (start)
		rdata_o <= sel_count;
end

endmodule

/* verilog/l1_cache.sv */
module l1_cache import lc3b_mem_pkg::*;
(
	input logic clk,
	input logic rst_n_i,
	input cpu_req_t req_i,
	output cpu_rsp_t rsp_o,
	output pmem_req_t pmem_req_o,
	input pmem_rsp_t pmem_rsp_i,
	output lc3b_word hit_count_o,
	output lc3b_word miss_count_o,
	input logic clear_hits_i,
	input logic clear_miss_i
);

typedef enum logic [1:0]
{
	s_idle,
	s_compare,
	s_write_back,
	s_fill
} state_t;

state_t state, next_state;

lc3b_line data_arr [NUM_SETS];
logic [TAG_W-1:0] tag_arr [NUM_SETS];
logic [NUM_SETS-1:0] valid;
logic [NUM_SETS-1:0] dirty;

logic [$clog2(NUM_SETS)-1:0] set_idx;
logic [2:0] word_sel;
logic req_pend;
logic hit;
logic first_look;
lc3b_line cur_line;
lc3b_word cur_word;
lc3b_word merged_word;

assign set_idx = req_i.addr.cache.set;
assign word_sel = req_i.addr.cache.offset[3:1];
assign cur_line = data_arr[set_idx];
assign cur_word = cur_line[word_sel*16 +: 16];
assign req_pend = req_i.read | req_i.write;
assign hit = valid[set_idx] && (tag_arr[set_idx] == req_i.addr.cache.tag);
assign first_look = (state == s_idle) && req_pend; // counted here only

always_comb
begin
	merged_word = cur_word;
	if (req_i.wmask[0])
		merged_word[7:0] = req_i.wdata[7:0];
	if (req_i.wmask[1])
		merged_word[15:8] = req_i.wdata[15:8];
end

always_comb
begin
	next_state = state;
	case (state)
		s_idle:
			if (req_pend)
				next_state = s_compare;
		s_compare:
		begin
			if (hit)
				next_state = s_idle;
			else if (valid[set_idx] && dirty[set_idx])
				next_state = s_write_back; // old line goes out first
			else
				next_state = s_fill;
		end
		s_write_back:
			if (pmem_rsp_i.resp)
				next_state = s_fill;
		s_fill:
			if (pmem_rsp_i.resp)
				next_state = s_compare; // replay as a hit
		default:
			next_state = s_idle;
	endcase
end

always_ff @(posedge clk or negedge rst_n_i)
begin
	if (!rst_n_i)
		state <= s_idle;
	else
		state <= next_state;
end

assign rsp_o.rdata = cur_word;
assign rsp_o.resp = (state == s_compare) && hit;

always_comb
begin
	if (state == s_write_back)
		pmem_req_o.addr = {tag_arr[set_idx], set_idx, 4'h0};
	else
		pmem_req_o.addr = {req_i.addr.cache.tag, set_idx, 4'h0};
	pmem_req_o.wdata = cur_line;
	pmem_req_o.read = (state == s_fill);
	pmem_req_o.write = (state == s_write_back);
end

always_ff @(posedge clk)
begin
	if ((state == s_fill) && pmem_rsp_i.resp)
	begin
		data_arr[set_idx] <= pmem_rsp_i.rdata;
		tag_arr[set_idx] <= req_i.addr.cache.tag;
	end
	else if ((state == s_compare) && hit && req_i.write)
		data_arr[set_idx][word_sel*16 +: 16] <= merged_word;
end

always_ff @(posedge clk or negedge rst_n_i)
begin
	if (!rst_n_i)
	begin
		valid <= '0;
		dirty <= '0;
	end
	else if ((state == s_fill) && pmem_rsp_i.resp)
	begin
		valid[set_idx] <= 1'b1;
		dirty[set_idx] <= 1'b0;
	end
	else if ((state == s_compare) && hit && req_i.write)
		dirty[set_idx] <= 1'b1;
end

// clear strobe beats a same cycle count
always_ff @(posedge clk or negedge rst_n_i)
begin
	if (!rst_n_i)
	begin
		hit_count_o <= '0;
		miss_count_o <= '0;
	end
	else
	begin
		if (clear_hits_i)
			hit_count_o <= '0;
		else if (first_look && hit)
			hit_count_o <= hit_count_o + 16'd1;
		if (clear_miss_i)
			miss_count_o <= '0;
		else if (first_look && !hit)
			miss_count_o <= miss_count_o + 16'd1;
	end
end

endmodule

/* verilog/lc3b_mem_pkg.sv */
package lc3b_mem_pkg;

// cache geometry
localparam int NUM_SETS = 8;
localparam int TAG_W = 9;

// counter block sits on the top page of memory
localparam logic [11:0] IO_PAGE = 12'hfff;
localparam logic [3:0] IO_IHITS = 4'h0;
localparam logic [3:0] IO_IMISS = 4'h2;
localparam logic [3:0] IO_DHITS = 4'h4;
localparam logic [3:0] IO_DMISS = 4'h6;

typedef logic [15:0] lc3b_word;
typedef logic [127:0] lc3b_line;
typedef logic [1:0] lc3b_mem_wmask; // bit 0 low byte, bit 1 high byte

typedef struct packed {
	logic [TAG_W-1:0] tag;
	logic [$clog2(NUM_SETS)-1:0] set;
	logic [3:0] offset; // byte within the line
} cache_addr_t;

typedef struct packed {
	logic [11:0] page;
	logic [3:0] reg_sel;
} io_addr_t;

// one address word read as cache fields or as an io register select
typedef union packed {
	cache_addr_t cache;
	io_addr_t io;
} lc3b_addr;

typedef struct packed {
	lc3b_addr addr;
	lc3b_word wdata;
	logic read;
	logic write;
	lc3b_mem_wmask wmask;
} cpu_req_t;

typedef struct packed {
	lc3b_word rdata;
	logic resp;
} cpu_rsp_t;

typedef struct packed {
	logic [15:0] addr; // line aligned
	lc3b_line wdata;
	logic read;
	logic write;
} pmem_req_t;

typedef struct packed {
	lc3b_line rdata;
	logic resp;
} pmem_rsp_t;

endpackage

/* verilog/mem_hierarchy.sv */
module mem_hierarchy import lc3b_mem_pkg::*;
(
	input logic clk,
	input logic rst_n_i,
	input cpu_req_t ireq_i,
	output cpu_rsp_t irsp_o,
	input cpu_req_t dreq_i,
	output cpu_rsp_t drsp_o,
	output pmem_req_t pmem_req_o,
	input pmem_rsp_t pmem_rsp_i
);

cpu_req_t dcache_req;
cpu_rsp_t dcache_rsp;
logic io_read, io_write, io_resp;
lc3b_word io_rdata;
pmem_req_t ipmem_req, dpmem_req;
pmem_rsp_t ipmem_rsp, dpmem_rsp;
lc3b_word ihits, imiss, dhits, dmiss;
logic clear_ihits, clear_imiss, clear_dhits, clear_dmiss;

cache_arbiter arb0
(
	.clk,
	.rst_n_i,
	.dreq_i,
	.drsp_o,
	.dcache_req_o(dcache_req),
	.dcache_rsp_i(dcache_rsp),
	.io_read_o(io_read),
	.io_write_o(io_write),
	.io_rdata_i(io_rdata),
	.io_resp_i(io_resp),
	.ipmem_req_i(ipmem_req),
	.dpmem_req_i(dpmem_req),
	.ipmem_rsp_o(ipmem_rsp),
	.dpmem_rsp_o(dpmem_rsp),
	.pmem_req_o,
	.pmem_rsp_i
);

l1_cache icache
(
	.clk,
	.rst_n_i,
	.req_i(ireq_i),
	.rsp_o(irsp_o),
	.pmem_req_o(ipmem_req),
	.pmem_rsp_i(ipmem_rsp),
	.hit_count_o(ihits),
	.miss_count_o(imiss),
	.clear_hits_i(clear_ihits),
	.clear_miss_i(clear_imiss)
);

l1_cache dcache
(
	.clk,
	.rst_n_i,
	.req_i(dcache_req),
	.rsp_o(dcache_rsp),
	.pmem_req_o(dpmem_req),
	.pmem_rsp_i(dpmem_rsp),
	.hit_count_o(dhits),
	.miss_count_o(dmiss),
	.clear_hits_i(clear_dhits),
	.clear_miss_i(clear_dmiss)
);

io_counters io0
(
	.clk,
	.rst_n_i,
	.addr_i(dreq_i.addr), // page already checked by the arbiter
	.read_i(io_read),
	.write_i(io_write),
	.rdata_o(io_rdata),
	.resp_o(io_resp),
	.ihits_i(ihits),
	.imiss_i(imiss),
	.dhits_i(dhits),
	.dmiss_i(dmiss),
	.clear_ihits_o(clear_ihits),
	.clear_imiss_o(clear_imiss),
	.clear_dhits_o(clear_dhits),
	.clear_dmiss_o(clear_dmiss)
);

endmodule
